// ==== source/vend_pkg.sv ====
`default_nettype none

package vend_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths that carry a meaning
    //////////////////////////////////////////////////////////////////////

    // product slot index
    typedef logic [1:0] slot_t;
    // credit, one unit is one hundred won
    typedef logic [7:0] credit_t;
    // items left in one slot
    typedef logic [3:0] stock_t;

    //////////////////////////////////////////////////////////////////////
    // product table and limits
    //////////////////////////////////////////////////////////////////////

    localparam int NUM_SLOTS = 4;

    localparam credit_t SLOT_PRICE [NUM_SLOTS] = '{8'd10, 8'd12, 8'd15, 8'd18};
    localparam stock_t SLOT_INIT_STOCK [NUM_SLOTS] = '{4'd9, 4'd1, 4'd0, 4'd4};

    localparam stock_t STOCK_MAX = 4'd9;
    localparam credit_t CREDIT_MAX = 8'd99;

    // coin values
    localparam credit_t COIN_SMALL = 8'd1;
    localparam credit_t COIN_MID = 8'd5;
    localparam credit_t COIN_LARGE = 8'd10;

    // cycles between unit coins, about a million on the board
    localparam int DISPENSE_INTERVAL = 4;

    //////////////////////////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        CMD_NONE,
        CMD_SELECT,
        CMD_COIN,
        CMD_BUY,
        CMD_RETURN,
        CMD_RESTOCK
    } vend_cmd_t;

    typedef enum logic [2:0] {
        ST_NONE,
        ST_VENDED,
        ST_SOLD_OUT,
        ST_NO_CREDIT,
        ST_NO_SELECTION
    } vend_status_t;

    typedef enum logic [1:0] {
        DISP_IDLE,
        DISP_WAIT,
        DISP_PULSE
    } disp_state_t;

endpackage

`default_nettype wire

// ==== source/vend_cmd_decoder.sv ====
`default_nettype none

module vend_cmd_decoder
    import vend_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      btn_up,
    input  logic      btn_down,
    input  logic      btn_select,
    input  logic      btn_coin_small,
    input  logic      btn_coin_mid,
    input  logic      btn_coin_large,
    input  logic      btn_buy,
    input  logic      btn_return,
    input  logic      btn_restock,
    output slot_t     cursor,
    output vend_cmd_t cmd,
    output slot_t     cmd_slot,
    output credit_t   cmd_coin
);

    logic    move_press;
    logic    coin_press;
    credit_t coin_value;

    assign move_press = btn_up | btn_down;
    assign coin_press = btn_coin_small | btn_coin_mid | btn_coin_large;

    // one coin per cycle, smallest wins
    always_comb begin
        coin_value = '0;
        if (btn_coin_small) begin
            coin_value = COIN_SMALL;
        end else if (btn_coin_mid) begin
            coin_value = COIN_MID;
        end else if (btn_coin_large) begin
            coin_value = COIN_LARGE;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // cursor and command register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            cursor <= '0;
            cmd    <= CMD_NONE;
        end else begin
            cmd <= CMD_NONE;
            if (move_press) begin
                // up wins over down, both clamp at the ends
                if (btn_up) begin
                    if (cursor != '0) begin
                        cursor <= cursor - 1'b1;
                    end
                end else if (cursor != slot_t'(NUM_SLOTS - 1)) begin
                    cursor <= cursor + 1'b1;
                end
            end else if (btn_select) begin
                cmd <= CMD_SELECT;
            end else if (coin_press) begin
                cmd <= CMD_COIN;
            end else if (btn_buy) begin
                cmd <= CMD_BUY;
            end else if (btn_return) begin
                cmd <= CMD_RETURN;
            end else if (btn_restock) begin
                // admin check happens in the ledger
                cmd <= CMD_RESTOCK;
            end
        end
    end

    // payload of the command, meaningful only while cmd is set
    always_ff @(posedge clk) begin
        cmd_slot <= cursor;
        cmd_coin <= coin_value;
    end

endmodule

`default_nettype wire

// ==== source/vend_ledger.sv ====
`default_nettype none

module vend_ledger
    import vend_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         admin_mode,
    input  vend_cmd_t    cmd,
    input  slot_t        cmd_slot,
    input  credit_t      cmd_coin,
    input  slot_t        cursor,
    input  logic         refund_busy,
    output credit_t      credit,
    output stock_t       cursor_stock,
    output logic         selected_valid,
    output slot_t        selected_slot,
    output logic         status_valid,
    output vend_status_t status,
    output logic         refund_load,
    output credit_t      refund_amount
);

    stock_t       stock [NUM_SLOTS];
    stock_t       stock_nxt [NUM_SLOTS];
    credit_t      credit_nxt;
    logic         sel_valid_nxt;
    slot_t        sel_slot_nxt;
    logic         stat_valid_nxt;
    vend_status_t stat_nxt;
    logic [8:0]   coin_sum;
    credit_t      sel_price;

    //////////////////////////////////////////////////////////////////////
    // refund handoff
    //////////////////////////////////////////////////////////////////////

    // dispenser takes the whole credit on the edge that clears it
    assign refund_load   = (cmd == CMD_RETURN) && !refund_busy && (credit != '0);
    assign refund_amount = credit;

    // one extra bit so an oversized coin cannot wrap
    assign coin_sum  = {1'b0, credit} + {1'b0, cmd_coin};
    assign sel_price = SLOT_PRICE[selected_slot];

    //////////////////////////////////////////////////////////////////////
    // command execution
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        stock_nxt      = stock;
        credit_nxt     = credit;
        sel_valid_nxt  = selected_valid;
        sel_slot_nxt   = selected_slot;
        stat_valid_nxt = 1'b0;
        stat_nxt       = status;

        case (cmd)
            CMD_SELECT: begin
                if (selected_valid && (selected_slot == cmd_slot)) begin
                    // second press on the same slot deselects
                    sel_valid_nxt = 1'b0;
                end else if (stock[cmd_slot] != '0) begin
                    sel_valid_nxt = 1'b1;
                    sel_slot_nxt  = cmd_slot;
                end else begin
                    stat_valid_nxt = 1'b1;
                    stat_nxt       = ST_SOLD_OUT;
                end
            end
            CMD_COIN: begin
                // refused coin leaves the credit as it was
                if (coin_sum <= {1'b0, CREDIT_MAX}) begin
                    credit_nxt = coin_sum[7:0];
                end
            end
            CMD_BUY: begin
                stat_valid_nxt = 1'b1;
                if (!selected_valid) begin
                    stat_nxt = ST_NO_SELECTION;
                end else if (stock[selected_slot] == '0) begin
                    stat_nxt = ST_SOLD_OUT;
                end else if (credit < sel_price) begin
                    stat_nxt = ST_NO_CREDIT;
                end else begin
                    stock_nxt[selected_slot] = stock[selected_slot] - 1'b1;
                    credit_nxt    = credit - sel_price;
                    sel_valid_nxt = 1'b0;
                    stat_nxt      = ST_VENDED;
                end
            end
            CMD_RETURN: begin
                // ignored while a payout is still running
                if (refund_load) begin
                    credit_nxt = '0;
                end
            end
            CMD_RESTOCK: begin
                if (admin_mode && (stock[cmd_slot] < STOCK_MAX)) begin
                    stock_nxt[cmd_slot] = stock[cmd_slot] + 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // state registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            stock          <= SLOT_INIT_STOCK;
            credit         <= '0;
            selected_valid <= 1'b0;
            selected_slot  <= '0;
            status_valid   <= 1'b0;
            status         <= ST_NONE;
            cursor_stock   <= SLOT_INIT_STOCK[0];
        end else begin
            stock          <= stock_nxt;
            credit         <= credit_nxt;
            selected_valid <= sel_valid_nxt;
            selected_slot  <= sel_slot_nxt;
            status_valid   <= stat_valid_nxt;
            status         <= stat_nxt;
            // follows the new stock so a buy shows up at once
            cursor_stock   <= stock_nxt[cursor];
        end
    end

endmodule

`default_nettype wire

// ==== source/change_dispenser.sv ====
`default_nettype none

module change_dispenser
    import vend_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    refund_load,
    input  credit_t refund_amount,
    output logic    refund_busy,
    output logic    coin_out
);

    disp_state_t state;
    credit_t     remaining;
    logic [$clog2(DISPENSE_INTERVAL + 1)-1:0] interval_cnt;

    // one unit coin per pulse state
    assign coin_out    = (state == DISP_PULSE);
    assign refund_busy = (state != DISP_IDLE);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state        <= DISP_IDLE;
            remaining    <= '0;
            interval_cnt <= '0;
        end else begin
            case (state)
                DISP_IDLE: begin
                    if (refund_load) begin
                        remaining    <= refund_amount;
                        interval_cnt <= '0;
                        state        <= DISP_WAIT;
                    end
                end
                DISP_WAIT: begin
                    // wait the full interval before each coin
                    if (interval_cnt == $bits(interval_cnt)'(DISPENSE_INTERVAL - 1)) begin
                        interval_cnt <= '0;
                        state        <= DISP_PULSE;
                    end else begin
                        interval_cnt <= interval_cnt + 1'b1;
                    end
                end
                DISP_PULSE: begin
                    remaining <= remaining - 1'b1;
                    if (remaining == 8'd1) begin
                        state <= DISP_IDLE;
                    end else begin
                        state <= DISP_WAIT;
                    end
                end
                default: begin
                    state <= DISP_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/vend_top.sv ====
`default_nettype none

module vend_top
    import vend_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         btn_up,
    input  logic         btn_down,
    input  logic         btn_select,
    input  logic         btn_coin_small,
    input  logic         btn_coin_mid,
    input  logic         btn_coin_large,
    input  logic         btn_buy,
    input  logic         btn_return,
    input  logic         btn_restock,
    input  logic         admin_mode,
    output slot_t        cursor,
    output credit_t      credit,
    output stock_t       cursor_stock,
    output logic         selected_valid,
    output slot_t        selected_slot,
    output logic         status_valid,
    output vend_status_t status,
    output logic         coin_out,
    output logic         refund_busy
);

    // decoder to ledger
    vend_cmd_t cmd;
    slot_t     cmd_slot;
    credit_t   cmd_coin;

    // ledger to dispenser
    logic      refund_load;
    credit_t   refund_amount;

    vend_cmd_decoder decoder_i (
        .clk            (clk),
        .rst            (rst),
        .btn_up         (btn_up),
        .btn_down       (btn_down),
        .btn_select     (btn_select),
        .btn_coin_small (btn_coin_small),
        .btn_coin_mid   (btn_coin_mid),
        .btn_coin_large (btn_coin_large),
        .btn_buy        (btn_buy),
        .btn_return     (btn_return),
        .btn_restock    (btn_restock),
        .cursor         (cursor),
        .cmd            (cmd),
        .cmd_slot       (cmd_slot),
        .cmd_coin       (cmd_coin)
    );

    vend_ledger ledger_i (
        .clk            (clk),
        .rst            (rst),
        .admin_mode     (admin_mode),
        .cmd            (cmd),
        .cmd_slot       (cmd_slot),
        .cmd_coin       (cmd_coin),
        .cursor         (cursor),
        .refund_busy    (refund_busy),
        .credit         (credit),
        .cursor_stock   (cursor_stock),
        .selected_valid (selected_valid),
        .selected_slot  (selected_slot),
        .status_valid   (status_valid),
        .status         (status),
        .refund_load    (refund_load),
        .refund_amount  (refund_amount)
    );

    change_dispenser dispenser_i (
        .clk           (clk),
        .rst           (rst),
        .refund_load   (refund_load),
        .refund_amount (refund_amount),
        .refund_busy   (refund_busy),
        .coin_out      (coin_out)
    );

endmodule

`default_nettype wire

// ==== dv/vend_assertions.sv ====
`default_nettype none

module vend_assertions
    import vend_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        coin_out,
    input logic        refund_busy,
    input credit_t     credit,
    input logic        status_valid,
    input logic        refund_load,
    input disp_state_t disp_state
);

    // every unit coin follows a busy wait cycle of the same payout
    coin_only_when_busy: assert property (@(posedge clk) disable iff (!rst)
        coin_out |-> refund_busy && $past(refund_busy) && !$past(coin_out))
        else $error("coin_out pulsed outside a paced payout");

    credit_in_range: assert property (@(posedge clk) disable iff (!rst)
        credit <= CREDIT_MAX)
        else $error("credit went above its limit");

    status_one_cycle: assert property (@(posedge clk) disable iff (!rst)
        status_valid |=> !status_valid)
        else $error("status_valid stayed high for two cycles");

    // dispenser starts only on a load
    disp_start_on_load: assert property (@(posedge clk) disable iff (!rst)
        (disp_state == DISP_IDLE) && !refund_load |=> disp_state == DISP_IDLE)
        else $error("dispenser left idle without refund_load");

endmodule

bind vend_top vend_assertions assertions_i (
    .clk          (clk),
    .rst          (rst),
    .coin_out     (coin_out),
    .refund_busy  (refund_busy),
    .credit       (credit),
    .status_valid (status_valid),
    .refund_load  (refund_load),
    .disp_state   (dispenser_i.state)
);

`default_nettype wire

// ==== dv/vend_tb.sv ====
`default_nettype none

module vend_tb
    import vend_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLES_PER_STEP = int'(CREDIT_MAX) * (DISPENSE_INTERVAL + 1) + 10;

    logic         clk;
    logic         rst;
    logic         btn_up;
    logic         btn_down;
    logic         btn_select;
    logic         btn_coin_small;
    logic         btn_coin_mid;
    logic         btn_coin_large;
    logic         btn_buy;
    logic         btn_return;
    logic         btn_restock;
    logic         admin_mode;
    slot_t        cursor;
    credit_t      credit;
    stock_t       cursor_stock;
    logic         selected_valid;
    slot_t        selected_slot;
    logic         status_valid;
    vend_status_t status;
    logic         coin_out;
    logic         refund_busy;

    // one entry per step of the cases file
    string step_test [$];
    string step_action [$];
    int    step_arg [$];
    int    step_credit [$];
    int    step_stock [$];
    int    step_sel [$];
    int    step_status [$];

    bit           steps_loaded = 1'b0;
    int           coin_count = 0;
    int           coin_base;
    int           current_step;
    int           test_errors;
    int           total_errors;
    int           load_errors;
    int           pass_count;
    int           fail_count;
    vend_status_t seen_status;
    int           exp_cursor;
    int           exp_sel_slot;

    vend_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // unit coins paid out since the start of the run
    always @(negedge clk) begin
        if (coin_out) begin
            coin_count <= coin_count + 1;
        end
    end

    initial begin
        wait (steps_loaded);
        repeat (step_test.size() * CYCLES_PER_STEP) @(posedge clk);
        $display("timeout: the simulation ran past its cycle budget");
        $display("SOME TESTS FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic release_buttons();
        btn_up         = 1'b0;
        btn_down       = 1'b0;
        btn_select     = 1'b0;
        btn_coin_small = 1'b0;
        btn_coin_mid   = 1'b0;
        btn_coin_large = 1'b0;
        btn_buy        = 1'b0;
        btn_return     = 1'b0;
        btn_restock    = 1'b0;
    endtask

    task automatic drive_button(input string name, input logic level, output bit known);
        known = 1'b1;
        case (name)
            "up": btn_up = level;
            "down": btn_down = level;
            "select": btn_select = level;
            "coin_small": btn_coin_small = level;
            "coin_mid": btn_coin_mid = level;
            "coin_large": btn_coin_large = level;
            "buy": btn_buy = level;
            "return": btn_return = level;
            "restock": btn_restock = level;
            default: known = 1'b0;
        endcase
    endtask

    // one cycle, buttons low, remembers any status event
    task automatic watch_cycle();
        @(negedge clk);
        release_buttons();
        if (status_valid) begin
            seen_status = status;
        end
    endtask

    task automatic press(input string name, input int count);
        bit known;
        for (int k = 0; k < count; k++) begin
            @(negedge clk);
            drive_button(name, 1'b1, known);
            if (!known) begin
                $display("step %0d: unknown action %s in the cases file", current_step, name);
                test_errors++;
                return;
            end
            repeat (3) begin
                watch_cycle();
            end
        end
    endtask

    // cursor after a run of moves, up goes toward slot 0, clamped at both ends
    function automatic int moved_cursor(input int pos, input string action, input int count);
        int pos_new;
        pos_new = pos;
        if (action == "up") begin
            pos_new = pos - count;
        end else if (action == "down") begin
            pos_new = pos + count;
        end
        if (pos_new < 0) begin
            pos_new = 0;
        end else if (pos_new > NUM_SLOTS - 1) begin
            pos_new = NUM_SLOTS - 1;
        end
        return pos_new;
    endfunction

    task automatic check_value(input string sig, input int got, input int expected);
        if (got != expected) begin
            $display("Mismatch %s: expected 0x%0h, got 0x%0h (step %0d)",
                     sig, expected, got, current_step);
            test_errors++;
        end
    endtask

    task automatic wait_refund(input int expected);
        int got;
        watch_cycle();
        while (refund_busy) begin
            watch_cycle();
        end
        got = coin_count - coin_base;
        coin_base = coin_count;
        check_value("coin_out count", got, expected);
    endtask

    task automatic run_step(input int i);
        seen_status = ST_NONE;
        case (step_action[i])
            "admin": begin
                @(negedge clk);
                admin_mode = (step_arg[i] != 0);
                watch_cycle();
            end
            "wait_refund": wait_refund(step_arg[i]);
            default: press(step_action[i], step_arg[i]);
        endcase
        exp_cursor = moved_cursor(exp_cursor, step_action[i], step_arg[i]);
        // a successful select takes the slot under the cursor
        if (step_action[i] == "select" && step_sel[i] != 0 &&
            step_status[i] != int'(ST_SOLD_OUT)) begin
            exp_sel_slot = exp_cursor;
        end
        check_value("credit", int'(credit), step_credit[i]);
        check_value("cursor_stock", int'(cursor_stock), step_stock[i]);
        check_value("selected_valid", int'(selected_valid), step_sel[i]);
        check_value("status", int'(seen_status), step_status[i]);
        check_value("cursor", int'(cursor), exp_cursor);
        if (step_sel[i] != 0) begin
            check_value("selected_slot", int'(selected_slot), exp_sel_slot);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int    fd;
        int    n;
        int    scan_arg;
        int    scan_credit;
        int    scan_stock;
        int    scan_sel;
        int    scan_status;
        string line;
        string scan_name;
        string scan_action;

        rst = 1'b0;
        admin_mode = 1'b0;
        release_buttons();
        coin_base = 0;
        test_errors = 0;
        total_errors = 0;
        load_errors = 0;
        pass_count = 0;
        fail_count = 0;
        exp_cursor = 0;
        exp_sel_slot = 0;
        void'($urandom(30161));

        fd = $fopen("dv/vend_cases.txt", "r");
        if (fd == 0) begin
            $display("error: could not open dv/vend_cases.txt");
            load_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                // skip blank lines and comments
                if (line.len() > 1 && line.getc(0) != 8'h23) begin
                    n = $sscanf(line, "%s %s %d %d %d %d %d", scan_name, scan_action,
                                scan_arg, scan_credit, scan_stock, scan_sel, scan_status);
                    if (n == 7) begin
                        step_test.push_back(scan_name);
                        step_action.push_back(scan_action);
                        step_arg.push_back(scan_arg);
                        step_credit.push_back(scan_credit);
                        step_stock.push_back(scan_stock);
                        step_sel.push_back(scan_sel);
                        step_status.push_back(scan_status);
                    end else begin
                        $display("error: malformed line in the cases file: %s", line);
                        load_errors++;
                    end
                end
            end
            $fclose(fd);
        end
        steps_loaded = (step_test.size() > 0);

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b1;

        for (int i = 0; i < step_test.size(); i++) begin
            repeat ($urandom % 4) @(negedge clk);
            current_step = i;
            run_step(i);
            // a test ends where the name changes
            if (i == step_test.size() - 1 || step_test[i + 1] != step_test[i]) begin
                $display("test %s: %s", step_test[i], (test_errors == 0) ? "passed" : "failed");
                if (test_errors == 0) begin
                    pass_count++;
                end else begin
                    fail_count++;
                end
                total_errors += test_errors;
                test_errors = 0;
            end
        end

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 pass_count + fail_count, pass_count, fail_count, total_errors + load_errors);
        if (fail_count == 0 && load_errors == 0 && pass_count > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/vend_cases.txt ====
# test action arg credit cursor_stock selected_valid status
# arg is the press count, the admin level or the refund coins; status 0 none 1 vended 2 sold_out 3 no_credit 4 no_selection
reset_move up 1 0 9 0 0
reset_move down 4 0 4 0 0
coins coin_small 1 1 4 0 0
coins coin_mid 1 6 4 0 0
coins coin_large 1 16 4 0 0
refusals up 1 16 0 0 0
refusals select 1 16 0 0 2
refusals buy 1 16 0 0 4
refusals down 1 16 4 0 0
refusals select 1 16 4 1 0
refusals buy 1 16 4 1 3
vend up 3 16 9 1 0
vend select 1 16 9 1 0
vend buy 1 6 8 0 1
vend select 1 6 8 1 0
vend select 1 6 8 0 0
refund return 1 0 8 0 0
refund coin_small 1 1 8 0 0
refund return 1 1 8 0 0
refund wait_refund 6 1 8 0 0
restock down 1 1 1 0 0
restock restock 1 1 1 0 0
restock admin 1 1 1 0 0
restock restock 1 1 2 0 0
restock restock 9 1 9 0 0
restock admin 0 1 9 0 0
coin_limit coin_large 9 91 9 0 0
coin_limit coin_mid 1 96 9 0 0
coin_limit coin_small 3 99 9 0 0
coin_limit coin_large 1 99 9 0 0
coin_limit coin_small 1 99 9 0 0

// ==== flist.f ====
source/vend_pkg.sv
source/vend_cmd_decoder.sv
source/vend_ledger.sv
source/change_dispenser.sv
source/vend_top.sv
dv/vend_assertions.sv
dv/vend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f flist.f --top-module vend_tb -o vend_sim
./obj_dir/vend_sim 2>&1 | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "run_sim: pass"
    exit 0
else
    echo "run_sim: fail, see sim.log"
    exit 1
fi
